/* Bender.yml */
package:
  name: rvcore

sources:
  - include_dirs:
      - logic
    files:
      - logic/rvcore_pkg.sv
      - logic/rvcore_regfile.sv
      - logic/rvcore_fetch.sv
      - logic/rvcore_execute.sv
      - logic/rvcore_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verification/rvcore_tb.sv

/* files.f */
+incdir+logic
logic/rvcore_pkg.sv
logic/rvcore_regfile.sv
logic/rvcore_fetch.sv
logic/rvcore_execute.sv
logic/rvcore_top.sv
verification/rvcore_tb.sv

/* logic/rvcore_execute.sv */
`timescale 1ns/100ps
`include "rvcore_settings.svh"

module rvcore_execute (
    input  logic                 clk,
    input  logic                 i_rst_n,

    input  logic                 i_f2e_valid,
    input  rvcore_pkg::instr_t   i_f2e_instr,
    input  rvcore_pkg::word_t    i_f2e_pc,

    output logic                 o_e2f_ready,
    output logic                 o_e2f_redirect,
    output rvcore_pkg::word_t    o_e2f_target,

    output rvcore_pkg::reg_idx_t o_rs1_addr,
    output rvcore_pkg::reg_idx_t o_rs2_addr,
    input  rvcore_pkg::word_t    i_rs1_data,
    input  rvcore_pkg::word_t    i_rs2_data,
    output rvcore_pkg::reg_idx_t o_rd_addr,
    output rvcore_pkg::word_t    o_rd_wdata,
    output logic                 o_rd_write,

    output logic                 o_dbus_transaction,
    output logic                 o_dbus_write,
    output rvcore_pkg::word_t    o_dbus_address,
    output rvcore_pkg::word_t    o_dbus_wdata,
    input  logic                 i_dbus_done,
    input  rvcore_pkg::word_t    i_dbus_rdata,

    output logic                 o_halted
);

    rvcore_pkg::exec_state_t state_q;
    logic                    dbus_trans_q;
    logic                    dbus_write_q;
    rvcore_pkg::word_t       dbus_addr_q;
    rvcore_pkg::word_t       dbus_wdata_q;
    rvcore_pkg::reg_idx_t    load_rd_q;

    logic [6:0]              opcode;
    logic [2:0]              funct3;
    logic [6:0]              funct7;
    rvcore_pkg::reg_idx_t    rd;
    rvcore_pkg::word_t       imm_i;
    rvcore_pkg::word_t       imm_s;
    rvcore_pkg::word_t       imm_b;
    rvcore_pkg::word_t       imm_u;
    rvcore_pkg::word_t       imm_j;

    logic                    accept;
    logic                    in_mem_wait;
    logic                    load_done;
    logic                    is_store;
    logic                    alu_write;
    rvcore_pkg::word_t       alu_result;
    logic                    jump;
    rvcore_pkg::word_t       jump_target;
    logic                    mem_op;
    logic                    illegal;
    rvcore_pkg::word_t       mem_addr;

    // Field extraction
    assign opcode = i_f2e_instr[6:0];
    assign rd     = i_f2e_instr[11:7];
    assign funct3 = i_f2e_instr[14:12];
    assign funct7 = i_f2e_instr[31:25];

    assign o_rs1_addr = i_f2e_instr[19:15];
    assign o_rs2_addr = i_f2e_instr[24:20];

    // Immediate formats
    assign imm_i = {{20{i_f2e_instr[31]}}, i_f2e_instr[31:20]};
    assign imm_s = {{20{i_f2e_instr[31]}}, i_f2e_instr[31:25], i_f2e_instr[11:7]};
    assign imm_b = {{19{i_f2e_instr[31]}}, i_f2e_instr[31], i_f2e_instr[7],
                    i_f2e_instr[30:25], i_f2e_instr[11:8], 1'b0};
    assign imm_u = {i_f2e_instr[31:12], 12'h000};
    assign imm_j = {{11{i_f2e_instr[31]}}, i_f2e_instr[31], i_f2e_instr[19:12],
                    i_f2e_instr[20], i_f2e_instr[30:21], 1'b0};

    assign accept      = i_f2e_valid && o_e2f_ready;
    assign in_mem_wait = (state_q == rvcore_pkg::EX_MEM_WAIT);
    assign load_done   = in_mem_wait && i_dbus_done && !dbus_write_q;
    assign is_store    = (opcode == `RVCORE_OP_STORE);
    assign mem_addr    = i_rs1_data + (is_store ? imm_s : imm_i);

    // Decode, ALU and branch resolution
    always_comb begin
        alu_write   = 1'b0;
        alu_result  = i_rs1_data + imm_i;
        jump        = 1'b0;
        jump_target = i_f2e_pc + imm_b;
        mem_op      = 1'b0;
        illegal     = 1'b0;
        case (opcode)
            `RVCORE_OP_LUI: begin
                alu_write  = 1'b1;
                alu_result = imm_u;
            end
            `RVCORE_OP_OPIMM: begin
                // ADDI only
                alu_write = (funct3 == 3'b000);
                illegal   = (funct3 != 3'b000);
            end
            `RVCORE_OP_OP: begin
                alu_write = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: alu_result = i_rs1_data + i_rs2_data;
                    10'b0100000_000: alu_result = i_rs1_data - i_rs2_data;
                    10'b0000000_111: alu_result = i_rs1_data & i_rs2_data;
                    10'b0000000_110: alu_result = i_rs1_data | i_rs2_data;
                    default: begin
                        alu_write = 1'b0;
                        illegal   = 1'b1;
                    end
                endcase
            end
            `RVCORE_OP_LOAD, `RVCORE_OP_STORE: begin
                // Word accesses only
                mem_op  = (funct3 == 3'b010);
                illegal = (funct3 != 3'b010);
            end
            `RVCORE_OP_BRANCH: begin
                case (funct3)
                    3'b000:  jump = (i_rs1_data == i_rs2_data);
                    3'b001:  jump = (i_rs1_data != i_rs2_data);
                    default: illegal = 1'b1;
                endcase
            end
            `RVCORE_OP_JAL: begin
                alu_write   = 1'b1;
                alu_result  = i_f2e_pc + 32'd4;
                jump        = 1'b1;
                jump_target = i_f2e_pc + imm_j;
            end
            default: illegal = 1'b1;
        endcase
    end

    assign o_e2f_ready    = (state_q == rvcore_pkg::EX_IDLE);
    assign o_e2f_redirect = accept && jump;
    assign o_e2f_target   = jump_target;

    // Load data takes the write port while the data bus is busy
    assign o_rd_write = (accept && alu_write) || load_done;
    assign o_rd_addr  = in_mem_wait ? load_rd_q : rd;
    assign o_rd_wdata = in_mem_wait ? i_dbus_rdata : alu_result;

    assign o_dbus_transaction = dbus_trans_q;
    assign o_dbus_write       = dbus_write_q;
    assign o_dbus_address     = dbus_addr_q;
    assign o_dbus_wdata       = dbus_wdata_q;

    assign o_halted = (state_q == rvcore_pkg::EX_HALT);

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state_q      <= rvcore_pkg::EX_IDLE;
            dbus_trans_q <= 1'b0;
            dbus_write_q <= 1'b0;
        end else begin
            case (state_q)
                rvcore_pkg::EX_IDLE: begin
                    if (accept && illegal) begin
                        state_q <= rvcore_pkg::EX_HALT;
                    end else if (accept && mem_op) begin
                        state_q      <= rvcore_pkg::EX_MEM_WAIT;
                        dbus_trans_q <= 1'b1;
                        dbus_write_q <= is_store;
                    end
                end
                rvcore_pkg::EX_MEM_WAIT: begin
                    if (i_dbus_done) begin
                        state_q      <= rvcore_pkg::EX_IDLE;
                        dbus_trans_q <= 1'b0;
                        dbus_write_q <= 1'b0;
                    end
                end
                // Halted until reset
                default: state_q <= rvcore_pkg::EX_HALT;
            endcase
        end
    end

    // Data bus payload, held for the whole transfer
    always_ff @(posedge clk) begin
        if (accept && mem_op) begin
            dbus_addr_q  <= mem_addr;
            dbus_wdata_q <= i_rs2_data;
            load_rd_q    <= rd;
        end
    end

endmodule

/* logic/rvcore_fetch.sv */
`timescale 1ns/100ps
`include "rvcore_settings.svh"

module rvcore_fetch (
    input  logic               clk,
    input  logic               i_rst_n,

    output logic               o_ibus_transaction,
    output rvcore_pkg::word_t  o_ibus_address,
    input  logic               i_ibus_done,
    input  rvcore_pkg::instr_t i_ibus_rdata,

    output logic               o_f2e_valid,
    output rvcore_pkg::instr_t o_f2e_instr,
    output rvcore_pkg::word_t  o_f2e_pc,

    input  logic               i_e2f_ready,
    input  logic               i_e2f_redirect,
    input  rvcore_pkg::word_t  i_e2f_target
);

    rvcore_pkg::word_t  pc_q;
    rvcore_pkg::word_t  req_addr_q;
    logic               req_q;
    logic               drop_q;
    logic               buf_valid_q;
    rvcore_pkg::instr_t buf_instr_q;

    logic               ret_valid;
    logic               buf_valid_d;
    logic               req_start;
    logic               req_busy_d;

    // Returning word that belongs to the current program flow
    assign ret_valid = req_q && i_ibus_done && !drop_q;

    // Execute may take the returning word directly without the buffer
    assign o_f2e_valid = buf_valid_q || ret_valid;
    assign o_f2e_instr = buf_valid_q ? buf_instr_q : i_ibus_rdata;

    // No new request starts while a word is parked, so the address still matches it
    assign o_f2e_pc    = req_addr_q;

    // Word stays parked while execute is busy
    assign buf_valid_d = o_f2e_valid && !i_e2f_ready && !i_e2f_redirect;

    // Next request once the bus is free and the buffer will be empty
    assign req_start  = (!req_q || i_ibus_done) && !buf_valid_d;
    assign req_busy_d = req_start || (req_q && !i_ibus_done);

    assign o_ibus_transaction = req_q;
    assign o_ibus_address     = req_addr_q;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            pc_q        <= `RVCORE_RESET_VECTOR;
            req_q       <= 1'b0;
            drop_q      <= 1'b0;
            buf_valid_q <= 1'b0;
        end else begin
            req_q       <= req_busy_d;
            buf_valid_q <= buf_valid_d;
            if (i_e2f_redirect) begin
                pc_q <= i_e2f_target;
                // Anything still on the bus after this edge is a wrong-path word
                drop_q <= req_busy_d;
            end else begin
                if (req_start) begin
                    pc_q <= pc_q + 32'd4;
                end
                if (req_q && i_ibus_done) begin
                    drop_q <= 1'b0;
                end
            end
        end
    end

    // Request address and buffered word
    always_ff @(posedge clk) begin
        if (req_start) begin
            req_addr_q <= pc_q;
        end
        if (ret_valid) begin
            buf_instr_q <= i_ibus_rdata;
        end
    end

endmodule

/* logic/rvcore_pkg.sv */
package rvcore_pkg;

    // Data, address and PC word
    typedef logic [31:0] word_t;

    // Architectural register index
    typedef logic [4:0] reg_idx_t;

    // Raw instruction word as fetched
    typedef logic [31:0] instr_t;

    // Execute stage sequencing
    typedef enum logic [1:0] {
        EX_IDLE     = 2'd0,
        EX_MEM_WAIT = 2'd1,
        EX_HALT     = 2'd2
    } exec_state_t;

endpackage

/* logic/rvcore_regfile.sv */
`timescale 1ns/100ps

module rvcore_regfile (
    input  logic                 clk,
    input  logic                 i_rst_n,

    input  rvcore_pkg::reg_idx_t i_rs1_addr,
    input  rvcore_pkg::reg_idx_t i_rs2_addr,
    output rvcore_pkg::word_t    o_rs1_rdata,
    output rvcore_pkg::word_t    o_rs2_rdata,

    input  rvcore_pkg::reg_idx_t i_rd_addr,
    input  rvcore_pkg::word_t    i_rd_wdata,
    input  logic                 i_rd_write
);

    rvcore_pkg::word_t regs [32];

    // x0 always reads as zero
    assign o_rs1_rdata = (i_rs1_addr == 5'd0) ? 32'd0 : regs[i_rs1_addr];
    assign o_rs2_rdata = (i_rs2_addr == 5'd0) ? 32'd0 : regs[i_rs2_addr];

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (i_rd_write && (i_rd_addr != 5'd0)) begin
            regs[i_rd_addr] <= i_rd_wdata;
        end
    end

endmodule

/* logic/rvcore_settings.svh */
`ifndef RVCORE_SETTINGS_SVH
`define RVCORE_SETTINGS_SVH

// First fetch address after reset
`define RVCORE_RESET_VECTOR 32'h0000_0000

// RV32I major opcodes in instr[6:0]
`define RVCORE_OP_LUI    7'b0110111
`define RVCORE_OP_OPIMM  7'b0010011
`define RVCORE_OP_OP     7'b0110011
`define RVCORE_OP_LOAD   7'b0000011
`define RVCORE_OP_STORE  7'b0100011
`define RVCORE_OP_BRANCH 7'b1100011
`define RVCORE_OP_JAL    7'b1101111

`endif

/* logic/rvcore_top.sv */
`timescale 1ns/100ps

module rvcore_top (
    input  logic               clk,
    input  logic               i_rst_n,

    output logic               o_ibus_transaction,
    output rvcore_pkg::word_t  o_ibus_address,
    input  logic               i_ibus_done,
    input  rvcore_pkg::instr_t i_ibus_rdata,

    output logic               o_dbus_transaction,
    output logic               o_dbus_write,
    output rvcore_pkg::word_t  o_dbus_address,
    output rvcore_pkg::word_t  o_dbus_wdata,
    input  logic               i_dbus_done,
    input  rvcore_pkg::word_t  i_dbus_rdata,

    output logic               o_halted
);

    // Fetch to execute
    logic                 f2e_valid;
    rvcore_pkg::instr_t   f2e_instr;
    rvcore_pkg::word_t    f2e_pc;

    // Execute to fetch
    logic                 e2f_ready;
    logic                 e2f_redirect;
    rvcore_pkg::word_t    e2f_target;

    // Register file ports
    rvcore_pkg::reg_idx_t rs1_addr;
    rvcore_pkg::reg_idx_t rs2_addr;
    rvcore_pkg::word_t    rs1_rdata;
    rvcore_pkg::word_t    rs2_rdata;
    rvcore_pkg::reg_idx_t rd_addr;
    rvcore_pkg::word_t    rd_wdata;
    logic                 rd_write;

    rvcore_fetch fetch (
        .clk                (clk),
        .i_rst_n            (i_rst_n),
        .o_ibus_transaction (o_ibus_transaction),
        .o_ibus_address     (o_ibus_address),
        .i_ibus_done        (i_ibus_done),
        .i_ibus_rdata       (i_ibus_rdata),
        .o_f2e_valid        (f2e_valid),
        .o_f2e_instr        (f2e_instr),
        .o_f2e_pc           (f2e_pc),
        .i_e2f_ready        (e2f_ready),
        .i_e2f_redirect     (e2f_redirect),
        .i_e2f_target       (e2f_target)
    );

    rvcore_execute execute (
        .clk                (clk),
        .i_rst_n            (i_rst_n),
        .i_f2e_valid        (f2e_valid),
        .i_f2e_instr        (f2e_instr),
        .i_f2e_pc           (f2e_pc),
        .o_e2f_ready        (e2f_ready),
        .o_e2f_redirect     (e2f_redirect),
        .o_e2f_target       (e2f_target),
        .o_rs1_addr         (rs1_addr),
        .o_rs2_addr         (rs2_addr),
        .i_rs1_data         (rs1_rdata),
        .i_rs2_data         (rs2_rdata),
        .o_rd_addr          (rd_addr),
        .o_rd_wdata         (rd_wdata),
        .o_rd_write         (rd_write),
        .o_dbus_transaction (o_dbus_transaction),
        .o_dbus_write       (o_dbus_write),
        .o_dbus_address     (o_dbus_address),
        .o_dbus_wdata       (o_dbus_wdata),
        .i_dbus_done        (i_dbus_done),
        .i_dbus_rdata       (i_dbus_rdata),
        .o_halted           (o_halted)
    );

    rvcore_regfile regfile (
        .clk                (clk),
        .i_rst_n            (i_rst_n),
        .i_rs1_addr         (rs1_addr),
        .i_rs2_addr         (rs2_addr),
        .o_rs1_rdata        (rs1_rdata),
        .o_rs2_rdata        (rs2_rdata),
        .i_rd_addr          (rd_addr),
        .i_rd_wdata         (rd_wdata),
        .i_rd_write         (rd_write)
    );

endmodule

/* verification/rvcore_tb.sv */
`timescale 1ns/100ps
`include "rvcore_settings.svh"

module rvcore_tb;

    // Program steps times worst-case cycles per step over both buses times a margin
    localparam int TIMEOUT_CYCLES = 25 * 16 * 10;

    logic               clk = 1'b0;
    logic               i_rst_n;
    logic               o_ibus_transaction;
    rvcore_pkg::word_t  o_ibus_address;
    logic               i_ibus_done;
    rvcore_pkg::instr_t i_ibus_rdata;
    logic               o_dbus_transaction;
    logic               o_dbus_write;
    rvcore_pkg::word_t  o_dbus_address;
    rvcore_pkg::word_t  o_dbus_wdata;
    logic               i_dbus_done;
    rvcore_pkg::word_t  i_dbus_rdata;
    logic               o_halted;

    rvcore_pkg::instr_t imem [256];
    rvcore_pkg::word_t  dmem [256];
    rvcore_pkg::word_t  ref_dmem [256];
    rvcore_pkg::word_t  exp_pc [64];
    rvcore_pkg::word_t  exp_st_addr [64];
    rvcore_pkg::word_t  exp_st_data [64];
    int                 n_exp_pc;
    int                 n_exp_st;
    int                 pc_idx = 0;
    int                 st_idx = 0;
    int                 cycle = 0;
    int                 fails [1:6];
    int                 total_fails;
    int                 tests_passed;
    int                 ibus_wait = -1;
    int                 dbus_wait = -1;
    integer             seed;
    logic               seen_fetch = 1'b0;
    logic               quiet;

    // Bus state one cycle back for the hold rule
    logic               ibus_waiting = 1'b0;
    logic               dbus_waiting = 1'b0;
    rvcore_pkg::word_t  ibus_addr_prev;
    rvcore_pkg::word_t  dbus_addr_prev;
    rvcore_pkg::word_t  dbus_wdata_prev;
    logic               dbus_write_prev;

    rvcore_top dut0 (
        .clk                (clk),
        .i_rst_n            (i_rst_n),
        .o_ibus_transaction (o_ibus_transaction),
        .o_ibus_address     (o_ibus_address),
        .i_ibus_done        (i_ibus_done),
        .i_ibus_rdata       (i_ibus_rdata),
        .o_dbus_transaction (o_dbus_transaction),
        .o_dbus_write       (o_dbus_write),
        .o_dbus_address     (o_dbus_address),
        .o_dbus_wdata       (o_dbus_wdata),
        .i_dbus_done        (i_dbus_done),
        .i_dbus_rdata       (i_dbus_rdata),
        .o_halted           (o_halted)
    );

    always #5 clk = ~clk;

    assign quiet = !o_ibus_transaction && !o_dbus_transaction && !o_halted;

    // Instruction encoders
    function automatic rvcore_pkg::instr_t lui_word(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, `RVCORE_OP_LUI};
    endfunction

    function automatic rvcore_pkg::instr_t imm_word(input logic [6:0] op, input logic [2:0] f3,
                                                    input logic [4:0] rd, input logic [4:0] rs1,
                                                    input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic rvcore_pkg::instr_t reg_word(input logic [6:0] f7, input logic [2:0] f3,
                                                    input logic [4:0] rd, input logic [4:0] rs1,
                                                    input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, `RVCORE_OP_OP};
    endfunction

    function automatic rvcore_pkg::instr_t store_word(input logic [4:0] rs2, input logic [4:0] rs1,
                                                      input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `RVCORE_OP_STORE};
    endfunction

    function automatic rvcore_pkg::instr_t branch_word(input logic [2:0] f3, input logic [4:0] rs1,
                                                       input logic [4:0] rs2,
                                                       input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `RVCORE_OP_BRANCH};
    endfunction

    function automatic rvcore_pkg::instr_t jal_word(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, `RVCORE_OP_JAL};
    endfunction

    // Preload value from the full byte address
    function automatic rvcore_pkg::word_t fill_word(input rvcore_pkg::word_t addr);
        return (addr * 32'h9e37_79b9) ^ 32'h5a5a_0000;
    endfunction

    function automatic int store_test(input int idx);
        if (idx < 4) begin
            return 2;
        end else if (idx == 4) begin
            return 3;
        end
        return 4;
    endfunction

    task automatic load_program();
        for (int i = 0; i < 256; i++) begin
            // Unused words carry their address and an opcode of zero
            imem[i]     = (i * 4) << 7;
            dmem[i]     = fill_word(i * 4);
            ref_dmem[i] = dmem[i];
        end
        imem[0]  = lui_word(1, 20'h12345);
        imem[1]  = imm_word(`RVCORE_OP_OPIMM, 3'b000, 1, 1, 12'h678);
        imem[2]  = imm_word(`RVCORE_OP_OPIMM, 3'b000, 2, 0, 12'h0f0);
        imem[3]  = reg_word(7'b0000000, 3'b000, 3, 1, 2);
        imem[4]  = reg_word(7'b0100000, 3'b000, 4, 1, 2);
        imem[5]  = reg_word(7'b0000000, 3'b111, 5, 1, 2);
        imem[6]  = reg_word(7'b0000000, 3'b110, 6, 1, 2);
        imem[7]  = imm_word(`RVCORE_OP_OPIMM, 3'b000, 10, 0, 12'h100);
        imem[8]  = store_word(3, 10, 12'd0);
        imem[9]  = store_word(4, 10, 12'd4);
        imem[10] = store_word(5, 10, 12'd8);
        imem[11] = store_word(6, 10, 12'd12);
        // Load of a preloaded word followed by a dependent add and store
        imem[12] = imm_word(`RVCORE_OP_LOAD, 3'b010, 7, 10, 12'h040);
        imem[13] = reg_word(7'b0000000, 3'b000, 8, 7, 1);
        imem[14] = store_word(8, 10, 12'd16);
        imem[15] = branch_word(3'b000, 1, 2, 13'd8);
        imem[16] = branch_word(3'b001, 1, 2, 13'd8);
        imem[17] = store_word(1, 10, 12'd20);
        imem[18] = branch_word(3'b000, 3, 3, 13'd8);
        imem[19] = store_word(2, 10, 12'd20);
        imem[20] = branch_word(3'b001, 3, 3, 13'd8);
        imem[21] = jal_word(9, 21'd12);
        imem[22] = store_word(1, 10, 12'd24);
        imem[23] = store_word(1, 10, 12'd28);
        imem[24] = store_word(9, 10, 12'd20);
        // Illegal opcode ends the program
        imem[25] = 32'hffff_ffff;
    endtask

    // Reference interpreter over the same image
    task automatic interpret();
        rvcore_pkg::word_t  x [32];
        rvcore_pkg::word_t  pc;
        rvcore_pkg::word_t  next_pc;
        rvcore_pkg::word_t  a;
        rvcore_pkg::word_t  b;
        rvcore_pkg::word_t  addr;
        rvcore_pkg::instr_t ins;
        logic               stop;
        for (int i = 0; i < 64; i++) begin
            exp_pc[i]      = 32'hffff_ffff;
            exp_st_addr[i] = 32'hffff_ffff;
            exp_st_data[i] = 32'hffff_ffff;
        end
        for (int i = 0; i < 32; i++) begin
            x[i] = 32'd0;
        end
        pc       = `RVCORE_RESET_VECTOR;
        n_exp_pc = 0;
        n_exp_st = 0;
        stop     = 1'b0;
        while (!stop && n_exp_pc < 64) begin
            ins = imem[pc[9:2]];
            exp_pc[n_exp_pc] = pc;
            n_exp_pc++;
            a       = x[ins[19:15]];
            b       = x[ins[24:20]];
            next_pc = pc + 32'd4;
            case (ins[6:0])
                `RVCORE_OP_LUI:   x[ins[11:7]] = {ins[31:12], 12'h000};
                `RVCORE_OP_OPIMM: x[ins[11:7]] = a + {{20{ins[31]}}, ins[31:20]};
                `RVCORE_OP_OP: begin
                    if (ins[30]) begin
                        x[ins[11:7]] = a - b;
                    end else if (ins[14:12] == 3'b111) begin
                        x[ins[11:7]] = a & b;
                    end else if (ins[14:12] == 3'b110) begin
                        x[ins[11:7]] = a | b;
                    end else begin
                        x[ins[11:7]] = a + b;
                    end
                end
                `RVCORE_OP_LOAD: begin
                    addr = a + {{20{ins[31]}}, ins[31:20]};
                    x[ins[11:7]] = ref_dmem[addr[9:2]];
                end
                `RVCORE_OP_STORE: begin
                    addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    ref_dmem[addr[9:2]]   = b;
                    exp_st_addr[n_exp_st] = addr;
                    exp_st_data[n_exp_st] = b;
                    n_exp_st++;
                end
                `RVCORE_OP_BRANCH: begin
                    // funct3 bit 0 picks BNE over BEQ
                    if ((a == b) != ins[12]) begin
                        next_pc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25],
                                        ins[11:8], 1'b0};
                    end
                end
                `RVCORE_OP_JAL: begin
                    x[ins[11:7]] = pc + 32'd4;
                    next_pc = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20],
                                    ins[30:21], 1'b0};
                end
                default: stop = 1'b1;
            endcase
            x[0] = 32'd0;
            pc   = next_pc;
        end
    endtask

    task automatic report_test(input int id, input string name);
        if (fails[id] == 0) begin
            $display("Test %0d %s: pass", id, name);
        end else begin
            $display("Test %0d %s: fail, %0d failing checks", id, name, fails[id]);
        end
    endtask

    // Memory models answer after 0 to 3 idle cycles
    always @(negedge clk) begin
        i_ibus_done = 1'b0;
        i_dbus_done = 1'b0;
        if (i_rst_n && o_ibus_transaction) begin
            if (ibus_wait < 0) begin
                ibus_wait = $random(seed) & 3;
            end
            if (ibus_wait == 0) begin
                i_ibus_done  = 1'b1;
                i_ibus_rdata = imem[o_ibus_address[9:2]];
            end
            ibus_wait = ibus_wait - 1;
        end
        if (i_rst_n && o_dbus_transaction) begin
            if (dbus_wait < 0) begin
                dbus_wait = $random(seed) & 3;
            end
            if (dbus_wait == 0) begin
                i_dbus_done = 1'b1;
                if (o_dbus_write) begin
                    dmem[o_dbus_address[9:2]] = o_dbus_wdata;
                end else begin
                    i_dbus_rdata = dmem[o_dbus_address[9:2]];
                end
            end
            dbus_wait = dbus_wait - 1;
        end
    end

    always @(posedge clk) begin
        cycle           <= cycle + 1;
        ibus_waiting    <= o_ibus_transaction && !i_ibus_done;
        dbus_waiting    <= o_dbus_transaction && !i_dbus_done;
        ibus_addr_prev  <= o_ibus_address;
        dbus_addr_prev  <= o_dbus_address;
        dbus_wdata_prev <= o_dbus_wdata;
        dbus_write_prev <= o_dbus_write;
        if (i_rst_n && o_ibus_transaction) begin
            seen_fetch <= 1'b1;
        end
        if (i_rst_n && dut0.f2e_valid && dut0.e2f_ready) begin
            pc_idx <= pc_idx + 1;
        end
        if (i_rst_n && o_dbus_transaction && o_dbus_write && i_dbus_done) begin
            st_idx <= st_idx + 1;
        end
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the program did not reach its end", cycle);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // Reset state
    assert property (@(posedge clk) (!i_rst_n && cycle > 0) |-> quiet ##1 quiet)
        else begin
            $display("Bus transaction or halt active during reset or the cycle after it");
            fails[1]++;
        end

    assert property (@(posedge clk) $rose(i_rst_n) |=> o_ibus_transaction)
        else begin
            $display("First instruction request missing in the cycle after reset");
            fails[1]++;
        end

    assert property (@(posedge clk) disable iff (!i_rst_n)
            (o_ibus_transaction && !seen_fetch) |-> o_ibus_address == `RVCORE_RESET_VECTOR)
        else begin
            $display("CHECK FAILED o_ibus_address: got %h expected %h",
                     $sampled(o_ibus_address), `RVCORE_RESET_VECTOR);
            fails[1]++;
        end

    // Stores against the interpreter
    assert property (@(posedge clk) disable iff (!i_rst_n)
            (o_dbus_transaction && o_dbus_write && i_dbus_done)
            |-> o_dbus_address == exp_st_addr[st_idx])
        else begin
            $display("CHECK FAILED o_dbus_address: got %h expected %h",
                     $sampled(o_dbus_address), exp_st_addr[$sampled(st_idx)]);
            fails[store_test($sampled(st_idx))]++;
        end

    assert property (@(posedge clk) disable iff (!i_rst_n)
            (o_dbus_transaction && o_dbus_write && i_dbus_done)
            |-> o_dbus_wdata == exp_st_data[st_idx])
        else begin
            $display("CHECK FAILED o_dbus_wdata: got %h expected %h",
                     $sampled(o_dbus_wdata), exp_st_data[$sampled(st_idx)]);
            fails[store_test($sampled(st_idx))]++;
        end

    // Instruction stream that reaches execute
    assert property (@(posedge clk) disable iff (!i_rst_n)
            (dut0.f2e_valid && dut0.e2f_ready) |-> dut0.f2e_pc == exp_pc[pc_idx])
        else begin
            $display("CHECK FAILED f2e_pc: got %h expected %h",
                     $sampled(dut0.f2e_pc), exp_pc[$sampled(pc_idx)]);
            fails[4]++;
        end

    // Bus hold rule
    assert property (@(posedge clk) disable iff (!i_rst_n)
            ibus_waiting |-> o_ibus_transaction && o_ibus_address == ibus_addr_prev)
        else begin
            $display("CHECK FAILED o_ibus_address: got %h expected %h while waiting for done",
                     $sampled(o_ibus_address), $sampled(ibus_addr_prev));
            fails[5]++;
        end

    assert property (@(posedge clk) disable iff (!i_rst_n)
            dbus_waiting |-> o_dbus_transaction && o_dbus_address == dbus_addr_prev
            && o_dbus_write == dbus_write_prev && o_dbus_wdata == dbus_wdata_prev)
        else begin
            $display("CHECK FAILED %s: got %h/%h/%h expected %h/%h/%h",
                     "o_dbus_address/o_dbus_write/o_dbus_wdata",
                     $sampled(o_dbus_address), $sampled(o_dbus_write), $sampled(o_dbus_wdata),
                     $sampled(dbus_addr_prev), $sampled(dbus_write_prev),
                     $sampled(dbus_wdata_prev));
            fails[5]++;
        end

    // Halt is sticky and quiets both buses
    assert property (@(posedge clk) disable iff (!i_rst_n) o_halted |=> o_halted)
        else begin
            $display("o_halted dropped before reset");
            fails[6]++;
        end

    assert property (@(posedge clk) disable iff (!i_rst_n)
            $past(o_halted) |-> !$rose(o_ibus_transaction) && !$rose(o_dbus_transaction))
        else begin
            $display("A new bus transaction started after the core halted");
            fails[6]++;
        end

    initial begin
        seed         = 32'hcbfb_c2a4;
        i_rst_n      = 1'b0;
        i_ibus_done  = 1'b0;
        i_ibus_rdata = 32'd0;
        i_dbus_done  = 1'b0;
        i_dbus_rdata = 32'd0;
        for (int t = 1; t <= 6; t++) begin
            fails[t] = 0;
        end
        load_program();
        interpret();

        repeat (16) @(negedge clk);
        i_rst_n = 1'b1;
        repeat (2) @(negedge clk);
        report_test(1, "reset state");

        wait (st_idx >= 4);
        @(negedge clk);
        report_test(2, "arithmetic");

        wait (st_idx >= 5);
        @(negedge clk);
        report_test(3, "loads");

        wait (o_halted);
        @(negedge clk);
        assert (pc_idx == n_exp_pc && st_idx == n_exp_st)
            else begin
                $display("Core ran %0d instructions and %0d stores, expected %0d and %0d",
                         pc_idx, st_idx, n_exp_pc, n_exp_st);
                fails[4]++;
            end
        report_test(4, "control flow");

        // Idle time after halt for the sticky and quiet checks
        repeat (20) @(negedge clk);
        assert (o_halted)
            else begin
                $display("Core is not halted at the end of the run");
                fails[6]++;
            end
        report_test(5, "bus rule");
        report_test(6, "halt");

        total_fails  = 0;
        tests_passed = 0;
        for (int t = 1; t <= 6; t++) begin
            total_fails += fails[t];
            if (fails[t] == 0) begin
                tests_passed++;
            end
        end
        $display("Tests run 6, passed %0d, failed %0d, failing checks %0d",
                 tests_passed, 6 - tests_passed, total_fails);
        if (total_fails == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
